// ==== include/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data and address width
`define CFG_XLEN 32

// Data RAM depth in 32-bit words
`define CFG_DMEM_WORDS 256

// Cycles from request acceptance to response valid, at least 1
`define CFG_DMEM_LATENCY 2

`endif

// ==== rtl/cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

	typedef enum logic [2:0] {
		SEL_ALU,
		SEL_MEM,
		SEL_CSR
	} wb_src_e;

	typedef enum logic [2:0] {
		MEM_LB,
		MEM_LBU,
		MEM_LH,
		MEM_LHU,
		MEM_LW,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

	localparam logic [31:0] CAUSE_DMEM_BUS_ERROR = 32'd5;	// Access fault on data bus

	typedef struct packed {
		logic [`CFG_XLEN-1:0]	pc;
		logic					rd_wena;
		logic [5:0]				rd_addr;
		logic [`CFG_XLEN-1:0]	rd_data;	// Byte address for memory items
		logic [`CFG_XLEN-1:0]	store_data;
		wb_src_e				wb_src;
		mem_op_e				mem_op;
		logic					exc_pend;
		logic [31:0]			exc_cause;
	} ex_mem_t;

	typedef struct packed {
		logic [`CFG_XLEN-1:0]	pc;
		logic					rd_wena;
		logic [5:0]				rd_addr;
		logic [`CFG_XLEN-1:0]	rd_data;
		wb_src_e				wb_src;
		logic					exc_pend;
		logic [31:0]			exc_cause;
	} mem_wb_t;

	typedef struct packed {
		logic [`CFG_XLEN-1:0]	addr;
		logic					write;
		logic [`CFG_XLEN-1:0]	wdata;
		logic [3:0]				wstrb;
	} dmem_req_t;

	typedef struct packed {
		logic [`CFG_XLEN-1:0]	rdata;
		logic [1:0]				resp;
		logic [1:0]				addr_lo;	// Byte offset of the read
	} dmem_rsp_t;

	function automatic logic is_store(mem_op_e op);
		return op inside {MEM_SB, MEM_SH, MEM_SW};
	endfunction

endpackage

// ==== rtl/dmem_request.sv ====
module dmem_request (
	input	logic					clk,
	input	logic					reset,
	input	logic					valid_in,
	input	cpu_pkg::ex_mem_t		ex_in,
	input	logic					issue_ok,
	input	logic					accept,
	input	logic					flush_out,
	output	logic					req_valid,
	output	cpu_pkg::dmem_req_t		req
);

	logic				issued;
	logic				issue_now;
	logic [1:0]			lane;
	cpu_pkg::dmem_req_t	req_next;

	assign issue_now = valid_in && ex_in.wb_src == cpu_pkg::SEL_MEM && !ex_in.exc_pend &&
		issue_ok && !issued;
	assign lane = ex_in.rd_data[1:0];

	always_comb begin
		req_next.addr = ex_in.rd_data;
		req_next.write = cpu_pkg::is_store(ex_in.mem_op);
		req_next.wdata = ex_in.store_data << {lane, 3'b000};	// Move data to its byte lane
		case (ex_in.mem_op)
			cpu_pkg::MEM_SB:	req_next.wstrb = 4'b0001 << lane;
			cpu_pkg::MEM_SH:	req_next.wstrb = 4'b0011 << lane;
			cpu_pkg::MEM_SW:	req_next.wstrb = 4'b1111;
			default:			req_next.wstrb = 4'b0000;	// Loads write nothing
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			req_valid <= 1'b0;
			issued <= 1'b0;
		end else begin
			req_valid <= issue_now;
			if (accept || flush_out)
				issued <= 1'b0;	// Item has left the stage input
			else if (issue_now)
				issued <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_now)
			req <= req_next;
	end

endmodule

// ==== rtl/data_ram.sv ====
`include "cpu_cfg.svh"

module data_ram (
	input	logic					clk,
	input	logic					reset,
	input	logic					req_valid,
	input	cpu_pkg::dmem_req_t		req,
	output	logic					rsp_valid,
	output	cpu_pkg::dmem_rsp_t		rsp,
	input	logic					rsp_ready
);

	localparam int LATENCY = `CFG_DMEM_LATENCY;
	localparam int IDX_W = $clog2(`CFG_DMEM_WORDS);
	localparam int CNT_W = $clog2(`CFG_DMEM_LATENCY + 1);
	localparam int unsigned RAM_BYTES = 4 * `CFG_DMEM_WORDS;

	logic [`CFG_XLEN-1:0]	mem [`CFG_DMEM_WORDS];
	logic [IDX_W-1:0]		idx;
	logic					in_range;
	logic					pending;
	logic [CNT_W-1:0]		cnt;

	assign idx = req.addr[2 +: IDX_W];
	assign in_range = req.addr < RAM_BYTES;

	always_ff @(posedge clk) begin
		if (req_valid && req.write && in_range) begin
			for (int b = 0; b < 4; b++) begin
				if (req.wstrb[b])
					mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
	end

	// Response payload captured at request time and held until taken
	always_ff @(posedge clk) begin
		if (req_valid) begin
			rsp.rdata <= in_range ? mem[idx] : '0;
			rsp.resp <= in_range ? 2'b00 : 2'b10;	// SLVERR beyond depth
			rsp.addr_lo <= req.addr[1:0];
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pending <= 1'b0;
			cnt <= '0;
		end else if (req_valid) begin
			pending <= 1'b1;
			cnt <= CNT_W'(LATENCY - 1);
		end else if (rsp_valid && rsp_ready) begin
			pending <= 1'b0;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign rsp_valid = pending && cnt == '0;

endmodule

// ==== rtl/mem_stage.sv ====
`include "cpu_cfg.svh"

module mem_stage (
	input	logic					clk,
	input	logic					reset,

	input	logic					valid_in,
	output	logic					ready_out,
	input	logic					flush_in,
	output	logic					flush_out,
	input	logic					exc_taken,
	output	logic					valid_out,
	input	logic					ready_in,

	input	cpu_pkg::ex_mem_t		ex_in,
	output	cpu_pkg::mem_wb_t		wb_out,

	input	logic					rsp_valid,
	input	cpu_pkg::dmem_rsp_t		rsp,
	output	logic					rsp_ready,

	output	logic					issue_ok,
	output	logic					accept
);

	logic					is_mem;
	logic					stall;
	logic [`CFG_XLEN-1:0]	rdata_aligned;
	logic [`CFG_XLEN-1:0]	load_data;
	cpu_pkg::mem_wb_t		wb_next;

	assign is_mem = ex_in.wb_src == cpu_pkg::SEL_MEM;

	// Hold input while an exception waits to retire or memory has not answered
	assign stall = wb_out.exc_pend || (is_mem && !ex_in.exc_pend && !rsp_valid);

	assign ready_out = ready_in && !stall;
	assign flush_out = flush_in || exc_taken;
	assign accept = valid_in && ready_out && !flush_out;
	assign rsp_ready = accept && is_mem && !ex_in.exc_pend;
	assign issue_ok = !wb_out.exc_pend && !flush_out;

	assign rdata_aligned = rsp.rdata >> {rsp.addr_lo, 3'b000};

	always_comb begin
		case (ex_in.mem_op)
			cpu_pkg::MEM_LB:
				load_data = {{(`CFG_XLEN-8){rdata_aligned[7]}}, rdata_aligned[7:0]};
			cpu_pkg::MEM_LBU:
				load_data = {{(`CFG_XLEN-8){1'b0}}, rdata_aligned[7:0]};
			cpu_pkg::MEM_LH:
				load_data = {{(`CFG_XLEN-16){rdata_aligned[15]}}, rdata_aligned[15:0]};
			cpu_pkg::MEM_LHU:
				load_data = {{(`CFG_XLEN-16){1'b0}}, rdata_aligned[15:0]};
			default:
				load_data = rdata_aligned;
		endcase
	end

	always_comb begin
		wb_next.pc = ex_in.pc;
		wb_next.rd_wena = ex_in.rd_wena;
		wb_next.rd_addr = ex_in.rd_addr;
		wb_next.rd_data = ex_in.rd_data;
		wb_next.wb_src = ex_in.wb_src;
		wb_next.exc_pend = ex_in.exc_pend;
		wb_next.exc_cause = ex_in.exc_cause;
		if (is_mem && !ex_in.exc_pend) begin
			if (|rsp.resp) begin
				wb_next.exc_pend = 1'b1;	// Address stays in rd_data
				wb_next.exc_cause = cpu_pkg::CAUSE_DMEM_BUS_ERROR;
			end else if (!cpu_pkg::is_store(ex_in.mem_op)) begin
				wb_next.rd_data = load_data;
			end
		end
	end

	// MEM/WB register
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
			wb_out <= '0;
		end else if (flush_out) begin
			valid_out <= 1'b0;
			wb_out <= '0;
		end else if (accept) begin
			valid_out <= 1'b1;
			wb_out <= wb_next;
		end else if (valid_out && ready_in) begin
			valid_out <= 1'b0;	// Drained with nothing behind it
			wb_out <= '0;
		end
	end

endmodule

// ==== rtl/trap_unit.sv ====
module trap_unit (
	input	logic				clk,
	input	logic				reset,
	input	logic				valid_out,
	input	logic				ready_in,
	input	cpu_pkg::mem_wb_t	wb_out,
	output	logic				exc_taken,
	output	logic [31:0]		trap_cause,
	output	logic [7:0]			trap_count
);

	// Exception is taken as the item retires
	assign exc_taken = valid_out && ready_in && wb_out.exc_pend;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			trap_cause <= '0;
			trap_count <= '0;
		end else if (exc_taken) begin
			trap_cause <= wb_out.exc_cause;
			trap_count <= trap_count + 8'd1;	// Wraps after 255
		end
	end

endmodule

// ==== rtl/mem_subsystem.sv ====
module mem_subsystem (
	input	logic				clk,
	input	logic				reset,
	input	logic				valid_in,
	input	cpu_pkg::ex_mem_t	ex_in,
	output	logic				ready_out,
	input	logic				flush_in,
	output	logic				flush_out,
	output	logic				valid_out,
	output	cpu_pkg::mem_wb_t	wb_out,
	input	logic				ready_in,
	output	logic [31:0]		trap_cause,
	output	logic [7:0]			trap_count
);

	logic					req_valid;
	cpu_pkg::dmem_req_t		req;
	logic					rsp_valid;
	cpu_pkg::dmem_rsp_t		rsp;
	logic					rsp_ready;
	logic					issue_ok;
	logic					accept;
	logic					exc_taken;

	dmem_request u_dmem_request (
		.clk		(clk),
		.reset		(reset),
		.valid_in	(valid_in),
		.ex_in		(ex_in),
		.issue_ok	(issue_ok),
		.accept		(accept),
		.flush_out	(flush_out),
		.req_valid	(req_valid),
		.req		(req)
	);

	data_ram u_data_ram (
		.clk		(clk),
		.reset		(reset),
		.req_valid	(req_valid),
		.req		(req),
		.rsp_valid	(rsp_valid),
		.rsp		(rsp),
		.rsp_ready	(rsp_ready)
	);

	mem_stage u_mem_stage (
		.clk		(clk),
		.reset		(reset),
		.valid_in	(valid_in),
		.ready_out	(ready_out),
		.flush_in	(flush_in),
		.flush_out	(flush_out),
		.exc_taken	(exc_taken),
		.valid_out	(valid_out),
		.ready_in	(ready_in),
		.ex_in		(ex_in),
		.wb_out		(wb_out),
		.rsp_valid	(rsp_valid),
		.rsp		(rsp),
		.rsp_ready	(rsp_ready),
		.issue_ok	(issue_ok),
		.accept		(accept)
	);

	trap_unit u_trap_unit (
		.clk		(clk),
		.reset		(reset),
		.valid_out	(valid_out),
		.ready_in	(ready_in),
		.wb_out		(wb_out),
		.exc_taken	(exc_taken),
		.trap_cause	(trap_cause),
		.trap_count	(trap_count)
	);

endmodule

// ==== verification/mem_subsystem_sva.sv ====
module mem_subsystem_sva (
	input	logic				clk,
	input	logic				reset,
	input	logic				req_valid,
	input	logic				rsp_valid,
	input	logic				rsp_ready,
	input	logic				accept,
	input	logic				flush_out,
	input	logic				valid_out,
	input	logic				ready_in,
	input	cpu_pkg::mem_wb_t	wb_out
);
	timeunit 1ns;
	timeprecision 1ps;

	logic seen_req;	// A request went out for the item at the stage input

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			seen_req <= 1'b0;
		else if (accept || flush_out)
			seen_req <= 1'b0;
		else if (req_valid)
			seen_req <= 1'b1;
	end

	a_one_req: assert property (@(posedge clk) disable iff (reset) req_valid |-> !seen_req)
		else $error("second request for one item");
	a_rsp_ready: assert property (@(posedge clk) disable iff (reset) rsp_ready |-> rsp_valid)
		else $error("rsp_ready without rsp_valid");
	a_hold: assert property (@(posedge clk) disable iff (reset)
		valid_out && !ready_in && !flush_out |=> $stable(wb_out))
		else $error("wb_out changed under back-pressure");
	a_flush: assert property (@(posedge clk) disable iff (reset) flush_out |=> !valid_out)
		else $error("valid_out after flush");

endmodule

bind mem_subsystem mem_subsystem_sva u_sva (
	.clk		(clk),
	.reset		(reset),
	.req_valid	(req_valid),
	.rsp_valid	(rsp_valid),
	.rsp_ready	(rsp_ready),
	.accept		(accept),
	.flush_out	(flush_out),
	.valid_out	(valid_out),
	.ready_in	(ready_in),
	.wb_out		(wb_out)
);

// ==== include/cpu_tb_cfg.svh ====
`ifndef CPU_TB_CFG_SVH
`define CPU_TB_CFG_SVH

// Fixed address the item behind a faulting access tries to store to
`define TB_VICTIM_ADDR 32'h40

`endif

// ==== verification/mem_subsystem_tb.sv ====
`include "cpu_cfg.svh"
`include "cpu_tb_cfg.svh"

module mem_subsystem_tb;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct {
		cpu_pkg::wb_src_e	wb_src;
		cpu_pkg::mem_op_e	mem_op;
		logic [31:0]		addr;	// ALU value for ALU items
		logic [31:0]		data;
		int					hold;	// Cycles with ready_in low after the result shows
		logic				exc_in;
		logic [31:0]		cause_in;
		logic [31:0]		exp_data;
		logic				exp_exc;
		logic [31:0]		exp_cause;
	} entry_t;

	logic clk, reset, valid_in, flush_in, ready_in, ready_out, flush_out, valid_out;
	cpu_pkg::ex_mem_t	ex_in;
	cpu_pkg::mem_wb_t	wb_out;
	logic [31:0]		trap_cause;
	logic [7:0]			trap_count;

	entry_t			stim_q[$];
	logic [7:0]		ref_mem [0:4*`CFG_DMEM_WORDS-1];	// Byte model of the RAM
	logic [31:0]	lcg_state = 32'hfbc7_eebc;
	int				cycles = 0;
	int				cycle_limit = 0;
	int				traps = 0;

	mem_subsystem u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic void ref_store(logic [31:0] addr, cpu_pkg::mem_op_e op, logic [31:0] data);
		logic [3:0]		strb;
		logic [31:0]	wdata;
		case (op)
			cpu_pkg::MEM_SB:	strb = 4'b0001 << addr[1:0];
			cpu_pkg::MEM_SH:	strb = 4'b0011 << addr[1:0];
			default:			strb = 4'b1111;
		endcase
		wdata = data << {addr[1:0], 3'b000};
		for (int b = 0; b < 4; b++)
			if (strb[b])
				ref_mem[int'(addr[9:2]) * 4 + b] = wdata[8*b +: 8];
	endfunction

	function automatic logic [31:0] ref_load(logic [31:0] addr, cpu_pkg::mem_op_e op);
		logic [31:0]	word;
		logic [31:0]	sh;
		for (int b = 0; b < 4; b++)
			word[8*b +: 8] = ref_mem[int'(addr[9:2]) * 4 + b];
		sh = word >> {addr[1:0], 3'b000};
		case (op)
			cpu_pkg::MEM_LB:	return {{24{sh[7]}}, sh[7:0]};
			cpu_pkg::MEM_LBU:	return {24'd0, sh[7:0]};
			cpu_pkg::MEM_LH:	return {{16{sh[15]}}, sh[15:0]};
			cpu_pkg::MEM_LHU:	return {16'd0, sh[15:0]};
			default:			return sh;
		endcase
	endfunction

	function automatic void add_entry(cpu_pkg::wb_src_e src, cpu_pkg::mem_op_e op,
		logic [31:0] addr, logic [31:0] data, int hold, logic exc_in, logic [31:0] cause_in);
		entry_t e;
		e = '{src, op, addr, data, hold, exc_in, cause_in, addr, exc_in, cause_in};
		if (!exc_in && src == cpu_pkg::SEL_MEM) begin
			if (addr >= 32'(4 * `CFG_DMEM_WORDS)) begin
				e.exp_exc = 1'b1;
				e.exp_cause = cpu_pkg::CAUSE_DMEM_BUS_ERROR;
			end else if (op inside {cpu_pkg::MEM_SB, cpu_pkg::MEM_SH, cpu_pkg::MEM_SW})
				ref_store(addr, op, data);
			else
				e.exp_data = ref_load(addr, op);
		end
		stim_q.push_back(e);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic run_entry(input entry_t e, input int idx);
		cpu_pkg::mem_wb_t	held;
		int					reqs;
		int					waits;
		logic				accepted;
		logic				mem_access;
		reqs = 0;
		waits = 0;
		accepted = 1'b0;
		mem_access = e.wb_src == cpu_pkg::SEL_MEM && !e.exc_in;
		ex_in = '{32'(idx * 4), 1'(idx % 2), 6'(idx % 32), e.addr, e.data, e.wb_src, e.mem_op,
			e.exc_in, e.cause_in};
		valid_in = 1'b1;
		ready_in = 1'b1;
		while (!accepted) begin
			#1;
			if (u_dut.req_valid)
				reqs++;
			accepted = ready_out && !flush_out;
			if (!accepted) begin
				waits++;
				@(negedge clk);
			end
		end
		// Issue the cycle after presentation, then the RAM latency
		check_value("accept wait", 32'(waits), mem_access ? 32'(`CFG_DMEM_LATENCY + 1) : 32'd0);
		@(negedge clk);
		if (u_dut.req_valid)
			reqs++;
		check_value("valid_out", 32'(valid_out), 32'd1);
		check_value("wb_out.pc", wb_out.pc, 32'(idx * 4));
		check_value("wb_out.rd_wena", 32'(wb_out.rd_wena), 32'(idx % 2));
		check_value("wb_out.rd_addr", 32'(wb_out.rd_addr), 32'(idx % 32));
		check_value("wb_out.wb_src", 32'(wb_out.wb_src), 32'(e.wb_src));
		check_value("wb_out.rd_data", wb_out.rd_data, e.exp_data);
		check_value("wb_out.exc_pend", 32'(wb_out.exc_pend), 32'(e.exp_exc));
		check_value("wb_out.exc_cause", wb_out.exc_cause, e.exp_exc ? e.exp_cause : e.cause_in);
		held = wb_out;
		valid_in = e.exp_exc;	// Item behind a fault gets flushed
		if (e.exp_exc)
			ex_in = '{32'hdead_0000, 1'b1, 6'd1, `TB_VICTIM_ADDR, 32'h0000_00a5,
				cpu_pkg::SEL_MEM, cpu_pkg::MEM_SB, 1'b0, 32'd0};
		ready_in = (e.hold == 0);
		#1;
		if (e.exp_exc)
			check_value("flush_out", 32'(flush_out), 32'd1);
		for (int h = 0; h < e.hold; h++) begin
			@(negedge clk);
			check_value("ready_out", 32'(ready_out), 32'd0);
			check_value("held wb_out.pc", wb_out.pc, held.pc);
			check_value("held wb_out.rd_data", wb_out.rd_data, held.rd_data);
			if (h == e.hold - 1)
				ready_in = 1'b1;
		end
		@(negedge clk);
		valid_in = 1'b0;
		check_value("valid_out", 32'(valid_out), 32'd0);
		if (e.exp_exc) begin
			traps++;
			check_value("trap_count", 32'(trap_count), 32'(traps));
			check_value("trap_cause", trap_cause, e.exp_cause);
			check_value("req_valid", 32'(u_dut.req_valid), 32'd0);
		end
		check_value("request count", 32'(reqs), mem_access ? 32'd1 : 32'd0);
	endtask

	function automatic void build_table();
		cpu_pkg::mem_op_e st_ops[3] = '{cpu_pkg::MEM_SB, cpu_pkg::MEM_SH, cpu_pkg::MEM_SW};
		cpu_pkg::mem_op_e ld_ops[5] = '{cpu_pkg::MEM_LB, cpu_pkg::MEM_LBU, cpu_pkg::MEM_LH,
			cpu_pkg::MEM_LHU, cpu_pkg::MEM_LW};
		for (int w = 0; w < 5; w++)
			add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SW, 32'(w * 4), lcg_next(), 0, 1'b0, 0);
		add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SW, `TB_VICTIM_ADDR, lcg_next(), 0, 1'b0, 0);
		for (int a = 0; a < 3; a++)
			add_entry(cpu_pkg::SEL_ALU, cpu_pkg::MEM_LW, lcg_next(), 0, a == 1 ? 3 : 0, 1'b0, 0);
		foreach (st_ops[s])
			for (int off = 0; off < 4; off++) begin
				add_entry(cpu_pkg::SEL_MEM, st_ops[s], 32'(16 + off), lcg_next(), 0, 1'b0, 0);
				add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LW, 32'd16, 0, 0, 1'b0, 0);
			end
		add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SW, 32'd8, 32'h80ff_7f01, 0, 1'b0, 0);
		for (int off = 0; off < 4; off++)
			foreach (ld_ops[l])
				add_entry(cpu_pkg::SEL_MEM, ld_ops[l], 32'(8 + off), 0, off == 1 ? 2 : 0, 1'b0, 0);
		add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SW, 32'(4 * `CFG_DMEM_WORDS), lcg_next(), 0,
			1'b0, 0);
		add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LW, `TB_VICTIM_ADDR, 0, 0, 1'b0, 0);
		add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LB, 32'h2000, 0, 0, 1'b0, 0);
		add_entry(cpu_pkg::SEL_ALU, cpu_pkg::MEM_LW, lcg_next(), 0, 0, 1'b0, 0);
		add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LW, 32'd4, 0, 0, 1'b1, 32'd13);
		add_entry(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LW, `TB_VICTIM_ADDR, 0, 0, 1'b0, 0);
	endfunction

	initial begin
		reset = 1'b1;
		valid_in = 1'b0;
		flush_in = 1'b0;
		ready_in = 1'b1;
		ex_in = '0;
		build_table();
		cycle_limit = stim_q.size() * (`CFG_DMEM_LATENCY + 6) + 50;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		foreach (stim_q[i])
			run_entry(stim_q[i], i);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/cpu_pkg.sv
rtl/dmem_request.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/trap_unit.sv
rtl/mem_subsystem.sv
verification/mem_subsystem_sva.sv
verification/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
	--top-module mem_subsystem_tb -o sim_mem_subsystem
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_mem_subsystem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: PASS" <<< "$output"; then
	exit 0
fi
exit 1
